//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_exec_unit
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+include
hw/alu_types_pkg.sv
hw/muldiv_pkg.sv
hw/alu_logic.sv
hw/mult_iter.sv
hw/div_radix2.sv
hw/hilo_reg.sv
hw/exec_unit.sv
tb/exec_unit_sva.sv
tb/tb_exec_unit.sv

//--- hw/alu_logic.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module alu_logic import alu_types_pkg::*; (
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    input  shamt_t  sa,
    output word_t   y,
    output logic    overflow
);
    logic   op_and, op_or, op_nor, op_xor;
    logic   op_add, op_addu, op_sub, op_subu;
    logic   op_slt, op_sltu;
    logic   op_sll, op_sll_sa, op_srl, op_sra, op_srl_sa, op_sra_sa;
    logic   op_lui, op_pass;
    logic   do_sub;
    word_t  adder_b;
    word_t  sum;
    logic   cout;
    word_t  slt_y, sltu_y;
    word_t  sll_y, sll_sa_y;
    dword_t sr64_y, sr64_sa_y;
    word_t  lui_y;

    assign op_and    = (op == `EXEC_OP_AND);
    assign op_or     = (op == `EXEC_OP_OR);
    assign op_nor    = (op == `EXEC_OP_NOR);
    assign op_xor    = (op == `EXEC_OP_XOR);
    assign op_add    = (op == `EXEC_OP_ADD);
    assign op_addu   = (op == `EXEC_OP_ADDU);
    assign op_sub    = (op == `EXEC_OP_SUB);
    assign op_subu   = (op == `EXEC_OP_SUBU);
    assign op_slt    = (op == `EXEC_OP_SLT);
    assign op_sltu   = (op == `EXEC_OP_SLTU);
    assign op_sll    = (op == `EXEC_OP_SLL);
    assign op_sll_sa = (op == `EXEC_OP_SLL_SA);
    assign op_srl    = (op == `EXEC_OP_SRL);
    assign op_sra    = (op == `EXEC_OP_SRA);
    assign op_srl_sa = (op == `EXEC_OP_SRL_SA);
    assign op_sra_sa = (op == `EXEC_OP_SRA_SA);
    assign op_lui    = (op == `EXEC_OP_LUI);
    assign op_pass   = (op == `EXEC_OP_PASS);

    // one adder, b inverted plus carry-in gives a - b
    assign do_sub  = op_sub | op_subu | op_slt | op_sltu;
    assign adder_b = b ^ {`EXEC_XLEN{do_sub}};
    assign {cout, sum} = {1'b0, a} + {1'b0, adder_b} + {{`EXEC_XLEN{1'b0}}, do_sub};

    // a < b signed: a negative and b not, or same signs and difference negative
    assign slt_y  = {{(`EXEC_XLEN-1){1'b0}},
                     (a[`EXEC_XLEN-1] & ~b[`EXEC_XLEN-1]) |
                     (~(a[`EXEC_XLEN-1] ^ b[`EXEC_XLEN-1]) & sum[`EXEC_XLEN-1])};
    assign sltu_y = {{(`EXEC_XLEN-1){1'b0}}, ~cout};  // borrow out

    assign sll_y    = b << a[`EXEC_SA_W-1:0];
    assign sll_sa_y = b << sa;
    assign sr64_y    = {{`EXEC_XLEN{op_sra & b[`EXEC_XLEN-1]}}, b} >> a[`EXEC_SA_W-1:0];
    assign sr64_sa_y = {{`EXEC_XLEN{op_sra_sa & b[`EXEC_XLEN-1]}}, b} >> sa;

    assign lui_y = {b[`EXEC_XLEN/2-1:0], {(`EXEC_XLEN/2){1'b0}}};

    assign y = ({`EXEC_XLEN{op_and}}                  & (a & b))                |
               ({`EXEC_XLEN{op_or}}                   & (a | b))                |
               ({`EXEC_XLEN{op_nor}}                  & ~(a | b))               |
               ({`EXEC_XLEN{op_xor}}                  & (a ^ b))                |
               ({`EXEC_XLEN{op_add | op_addu | op_sub | op_subu}} & sum)        |
               ({`EXEC_XLEN{op_slt}}                  & slt_y)                  |
               ({`EXEC_XLEN{op_sltu}}                 & sltu_y)                 |
               ({`EXEC_XLEN{op_sll}}                  & sll_y)                  |
               ({`EXEC_XLEN{op_sll_sa}}               & sll_sa_y)               |
               ({`EXEC_XLEN{op_srl | op_sra}}         & sr64_y[`EXEC_XLEN-1:0]) |
               ({`EXEC_XLEN{op_srl_sa | op_sra_sa}}   & sr64_sa_y[`EXEC_XLEN-1:0]) |
               ({`EXEC_XLEN{op_lui}}                  & lui_y)                  |
               ({`EXEC_XLEN{op_pass}}                 & a);

    // same-sign operands, result sign flipped
    assign overflow = (op_add | op_sub) &
                      (a[`EXEC_XLEN-1] == adder_b[`EXEC_XLEN-1]) &
                      (sum[`EXEC_XLEN-1] != a[`EXEC_XLEN-1]);

endmodule

//--- hw/alu_types_pkg.sv
`include "exec_params.svh"

package alu_types_pkg;

    // operand or result word
    typedef logic [`EXEC_XLEN-1:0] word_t;

    // hi in the upper word
    typedef logic [2*`EXEC_XLEN-1:0] dword_t;

    typedef logic [`EXEC_OP_W-1:0] alu_op_t;

    typedef logic [`EXEC_SA_W-1:0] shamt_t;

endpackage

//--- hw/div_radix2.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module div_radix2 import alu_types_pkg::*, muldiv_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   flush,
    input  logic   sign,
    input  word_t  a,
    input  word_t  b,
    output logic   done,
    output dword_t quot_rem
);
    localparam step_cnt_t LAST_STEP = step_cnt_t'(`EXEC_XLEN - 1);

    div_state_t          state;
    step_cnt_t           cnt;
    word_t               mag_a, mag_b;
    word_t               rem;
    word_t               quot;   // dividend shifts out as quotient shifts in
    word_t               dvsr;
    logic                neg_q, neg_r;
    logic                dz;
    logic [`EXEC_XLEN:0] shifted;
    logic [`EXEC_XLEN:0] diff;
    logic                q_bit;
    word_t               rem_n, quot_n;
    word_t               q_fix, r_fix;

    assign mag_a = (sign && a[`EXEC_XLEN-1]) ? -a : a;
    assign mag_b = (sign && b[`EXEC_XLEN-1]) ? -b : b;

    assign shifted = {rem, quot[`EXEC_XLEN-1]};
    assign diff    = shifted - {1'b0, dvsr};
    assign q_bit   = ~diff[`EXEC_XLEN];  // no borrow, keep the difference
    assign rem_n   = q_bit ? diff[`EXEC_XLEN-1:0] : shifted[`EXEC_XLEN-1:0];
    assign quot_n  = {quot[`EXEC_XLEN-2:0], q_bit};

    // remainder follows the dividend sign
    assign q_fix = dz ? '1 : (neg_q ? -quot_n : quot_n);
    assign r_fix = neg_r ? -rem_n : rem_n;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DIV_IDLE;
            cnt   <= '0;
        end else if (flush) begin
            state <= DIV_IDLE;
        end else if (start) begin
            state <= DIV_BUSY;
            cnt   <= '0;
        end else begin
            case (state)
                DIV_BUSY: begin
                    if (cnt == LAST_STEP) begin
                        state <= DIV_DONE;
                    end
                    cnt <= cnt + 1'b1;
                end
                DIV_DONE: state <= DIV_DONE;  // hold until next start
                default:  state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rem   <= '0;
            quot  <= mag_a;
            dvsr  <= mag_b;
            neg_q <= sign & (a[`EXEC_XLEN-1] ^ b[`EXEC_XLEN-1]);
            neg_r <= sign & a[`EXEC_XLEN-1];
            dz    <= (b == '0);
        end else if (state == DIV_BUSY) begin
            rem  <= rem_n;
            quot <= quot_n;
            if (cnt == LAST_STEP) begin
                quot_rem <= {r_fix, q_fix};
            end
        end
    end

    assign done = (state == DIV_DONE);

endmodule

//--- hw/exec_unit.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module exec_unit import alu_types_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    issue,
    input  logic    flush,
    input  logic    stall_m,
    input  alu_op_t alu_op,
    input  word_t   src_a,
    input  word_t   src_b,
    input  shamt_t  sa,
    output word_t   result,
    output logic    overflow,
    output logic    stall_e,
    output dword_t  hilo
);
    logic       is_mult, is_div, is_mt, is_long, is_single;
    logic       mult_start, div_start;
    logic       mult_done, div_done, long_done;
    dword_t     product, quot_rem;
    word_t      alu_y;
    logic       alu_ovf;
    logic       pend;   // long op issued, hi/lo not yet written
    logic       long_wr, mt_wr;
    logic [1:0] wr_kind;

    assign is_mult   = (alu_op == `EXEC_OP_MULT) | (alu_op == `EXEC_OP_MULTU);
    assign is_div    = (alu_op == `EXEC_OP_DIV) | (alu_op == `EXEC_OP_DIVU);
    assign is_mt     = (alu_op == `EXEC_OP_MTHI) | (alu_op == `EXEC_OP_MTLO);
    assign is_long   = is_mult | is_div;
    assign is_single = ~is_long & ~is_mt;

    assign mult_start = issue & is_mult;
    assign div_start  = issue & is_div;
    assign long_done  = is_mult ? mult_done : div_done;

    // issue cycle counts as the first stall cycle
    assign stall_e = is_long & ~flush & (issue | (pend & ~long_done));

    assign long_wr = pend & is_long & long_done & ~issue & ~stall_m & ~flush;
    assign mt_wr   = issue & is_mt & ~stall_m & ~flush;
    assign wr_kind = (alu_op == `EXEC_OP_MTHI) ? `EXEC_HILO_HI :
                     (alu_op == `EXEC_OP_MTLO) ? `EXEC_HILO_LO : `EXEC_HILO_FULL;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= 1'b0;
        end else if (flush) begin
            pend <= 1'b0;
        end else if (issue && is_long) begin
            pend <= 1'b1;
        end else if (long_wr) begin
            pend <= 1'b0;
        end
    end

    alu_logic alu_logic_inst (
        .op       (alu_op),
        .a        (src_a),
        .b        (src_b),
        .sa       (sa),
        .y        (alu_y),
        .overflow (alu_ovf)
    );

    mult_iter mult_iter_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (mult_start),
        .flush   (flush),
        .sign    (alu_op == `EXEC_OP_MULT),
        .a       (src_a),
        .b       (src_b),
        .done    (mult_done),
        .product (product)
    );

    div_radix2 div_radix2_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (div_start),
        .flush    (flush),
        .sign     (alu_op == `EXEC_OP_DIV),
        .a        (src_a),
        .b        (src_b),
        .done     (div_done),
        .quot_rem (quot_rem)
    );

    hilo_reg hilo_reg_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .we    (long_wr | mt_wr),
        .kind  (wr_kind),
        .full  (is_mult ? product : quot_rem),
        .word  (src_a),
        .hilo  (hilo)
    );

    assign result   = is_single ? alu_y : '0;
    assign overflow = is_single & alu_ovf;

endmodule

//--- hw/hilo_reg.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module hilo_reg import alu_types_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       we,
    input  logic [1:0] kind,
    input  dword_t     full,
    input  word_t      word,
    output dword_t     hilo
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hilo <= '0;
        end else if (we) begin
            case (kind)
                `EXEC_HILO_HI: begin
                    hilo[2*`EXEC_XLEN-1:`EXEC_XLEN] <= word;  // lo kept
                end
                `EXEC_HILO_LO: begin
                    hilo[`EXEC_XLEN-1:0] <= word;
                end
                default: begin
                    hilo <= full;  // product or quotient/remainder
                end
            endcase
        end
    end

endmodule

//--- hw/muldiv_pkg.sv
package muldiv_pkg;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_BUSY = 2'd1,
        DIV_DONE = 2'd2
    } div_state_t;

    // iteration count for both sequencers
    typedef logic [5:0] step_cnt_t;

endpackage

//--- hw/mult_iter.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module mult_iter import alu_types_pkg::*, muldiv_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   flush,
    input  logic   sign,
    input  word_t  a,
    input  word_t  b,
    output logic   done,
    output dword_t product
);
    localparam int        DW        = 2 * `EXEC_XLEN;
    localparam step_cnt_t LAST_STEP = step_cnt_t'(`EXEC_MULT_CYCLES - 1);

    word_t     mag_a, mag_b;
    dword_t    step_m;
    word_t     step_q;
    dword_t    step_acc;
    dword_t    partial;
    dword_t    mcand;   // shifted up one nibble per step
    word_t     mplier;
    dword_t    acc;
    logic      neg;
    logic      busy;
    step_cnt_t cnt;

    assign mag_a = (sign && a[`EXEC_XLEN-1]) ? -a : a;
    assign mag_b = (sign && b[`EXEC_XLEN-1]) ? -b : b;

    // first nibble is taken on the start edge itself
    assign step_m   = start ? {{`EXEC_XLEN{1'b0}}, mag_a} : mcand;
    assign step_q   = start ? mag_b : mplier;
    assign step_acc = start ? '0 : acc;

    assign partial = ({DW{step_q[0]}} & step_m)        +
                     ({DW{step_q[1]}} & (step_m << 1)) +
                     ({DW{step_q[2]}} & (step_m << 2)) +
                     ({DW{step_q[3]}} & (step_m << 3));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
            neg  <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
            cnt  <= step_cnt_t'(1);
            neg  <= sign & (a[`EXEC_XLEN-1] ^ b[`EXEC_XLEN-1]);
        end else if (busy) begin
            if (cnt == LAST_STEP) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start || (busy && cnt != LAST_STEP)) begin
            acc    <= step_acc + partial;
            mcand  <= step_m << 4;
            mplier <= step_q >> 4;
        end else if (busy && neg) begin
            acc <= -acc;  // sign fix cycle
        end
    end

    assign product = acc;

endmodule

//--- include/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

`define EXEC_XLEN        32
`define EXEC_OP_W        5
`define EXEC_SA_W        5
`define EXEC_MULT_CYCLES 9   // eight nibble steps plus sign fix

// operation codes
`define EXEC_OP_AND      5'd0
`define EXEC_OP_OR       5'd1
`define EXEC_OP_NOR      5'd2
`define EXEC_OP_XOR      5'd3
`define EXEC_OP_ADD      5'd4
`define EXEC_OP_ADDU     5'd5
`define EXEC_OP_SUB      5'd6
`define EXEC_OP_SUBU     5'd7
`define EXEC_OP_SLT      5'd8
`define EXEC_OP_SLTU     5'd9
`define EXEC_OP_SLL      5'd10
`define EXEC_OP_SLL_SA   5'd11
`define EXEC_OP_SRL      5'd12
`define EXEC_OP_SRA      5'd13
`define EXEC_OP_SRL_SA   5'd14
`define EXEC_OP_SRA_SA   5'd15
`define EXEC_OP_LUI      5'd16
`define EXEC_OP_PASS     5'd17
`define EXEC_OP_MULT     5'd18
`define EXEC_OP_MULTU    5'd19
`define EXEC_OP_DIV      5'd20
`define EXEC_OP_DIVU     5'd21
`define EXEC_OP_MTHI     5'd22
`define EXEC_OP_MTLO     5'd23

// hi/lo write kinds
`define EXEC_HILO_FULL   2'd0
`define EXEC_HILO_HI     2'd1
`define EXEC_HILO_LO     2'd2

`endif

//--- tb/exec_unit_sva.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module exec_unit_sva import alu_types_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    issue,
    input logic    flush,
    input logic    stall_m,
    input alu_op_t alu_op,
    input logic    stall_e,
    input dword_t  hilo
);
    logic mult_issue;

    assign mult_issue = issue & ~flush &
                        ((alu_op == `EXEC_OP_MULT) | (alu_op == `EXEC_OP_MULTU));

    // first clock out of reset
    reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (!stall_e && hilo == '0))
        else $error("stall_e or hilo not clear after reset");

    flush_drops_stall: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !stall_e)
        else $error("stall_e still high the cycle after flush");

    // last stall cycle, then released
    mult_stall_held: assert property (@(posedge clk) disable iff (!rst_n || flush)
        mult_issue |-> ##(`EXEC_MULT_CYCLES - 1) stall_e)
        else $error("multiply stall ended early");

    mult_stall_ends: assert property (@(posedge clk) disable iff (!rst_n || flush)
        mult_issue |-> ##(`EXEC_MULT_CYCLES) !stall_e)
        else $error("multiply stall too long");

    hilo_held: assert property (@(posedge clk) disable iff (!rst_n)
        stall_m |=> $stable(hilo))
        else $error("hilo written while stall_m high");

endmodule

//--- tb/tb_exec_unit.sv
`timescale 1ns/10ps
`include "exec_params.svh"

module tb_exec_unit import alu_types_pkg::*; ();
    localparam int CLK_PERIOD  = 8;
    localparam int SETTLE      = 2;    // sample point after the falling-edge drive
    localparam int STALL_LIMIT = 100;
    localparam int N_SINGLE    = 300;
    localparam int N_LONG      = 40;
    localparam int FLUSH_WATCH = 2 * `EXEC_XLEN;  // longer than any divide

    logic    clk;
    logic    rst_n;
    logic    issue;
    logic    flush;
    logic    stall_m;
    alu_op_t alu_op;
    word_t   src_a;
    word_t   src_b;
    shamt_t  sa;
    word_t   result;
    logic    overflow;
    logic    stall_e;
    dword_t  hilo;
    integer  seed;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    exec_unit exec_unit_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .flush    (flush),
        .stall_m  (stall_m),
        .alu_op   (alu_op),
        .src_a    (src_a),
        .src_b    (src_b),
        .sa       (sa),
        .result   (result),
        .overflow (overflow),
        .stall_e  (stall_e),
        .hilo     (hilo)
    );

    bind exec_unit exec_unit_sva exec_unit_sva_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue),
        .flush   (flush),
        .stall_m (stall_m),
        .alu_op  (alu_op),
        .stall_e (stall_e),
        .hilo    (hilo)
    );

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h (op %0d)", name, got, exp, alu_op);
            abort_run();
        end
    endtask

    task automatic check_dword(input string name, input dword_t got, input dword_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h (op %0d)", name, got, exp, alu_op);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h (op %0d)", name, got, exp, alu_op);
            abort_run();
        end
    endtask

    // corner values show up often
    function automatic word_t rand_operand();
        case ($random(seed) & 7)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return 32'h7fff_ffff;
            4:       return word_t'($random(seed) & 15);
            default: return word_t'($random(seed));
        endcase
    endfunction

    function automatic word_t model_alu(alu_op_t op, word_t a, word_t b, shamt_t s);
        case (op)
            `EXEC_OP_AND:                return a & b;
            `EXEC_OP_OR:                 return a | b;
            `EXEC_OP_NOR:                return ~(a | b);
            `EXEC_OP_XOR:                return a ^ b;
            `EXEC_OP_ADD, `EXEC_OP_ADDU: return a + b;
            `EXEC_OP_SUB, `EXEC_OP_SUBU: return a - b;
            `EXEC_OP_SLT:                return word_t'($signed(a) < $signed(b));
            `EXEC_OP_SLTU:               return word_t'(a < b);
            `EXEC_OP_SLL:                return b << a[4:0];
            `EXEC_OP_SLL_SA:             return b << s;
            `EXEC_OP_SRL:                return b >> a[4:0];
            `EXEC_OP_SRA:                return word_t'($signed(b) >>> a[4:0]);
            `EXEC_OP_SRL_SA:             return b >> s;
            `EXEC_OP_SRA_SA:             return word_t'($signed(b) >>> s);
            `EXEC_OP_LUI:                return {b[15:0], 16'h0000};
            `EXEC_OP_PASS:               return a;
            default:                     return '0;
        endcase
    endfunction

    // overflow when bits 32 and 31 of the exact sum differ
    function automatic logic model_ovf(alu_op_t op, word_t a, word_t b);
        longint sum;
        sum = 0;
        if (op == `EXEC_OP_ADD) begin
            sum = longint'($signed(a)) + longint'($signed(b));
        end else if (op == `EXEC_OP_SUB) begin
            sum = longint'($signed(a)) - longint'($signed(b));
        end
        return sum[32] != sum[31];
    endfunction

    function automatic dword_t model_mult(logic signed_op, word_t a, word_t b);
        if (signed_op) begin
            return dword_t'(longint'($signed(a)) * longint'($signed(b)));
        end
        return dword_t'(a) * dword_t'(b);
    endfunction

    // remainder in hi and quotient in lo
    function automatic dword_t model_div(logic signed_op, word_t a, word_t b);
        longint q;
        longint r;
        if (b == '0) begin
            return {a, 32'hffff_ffff};
        end
        if (signed_op) begin
            q = longint'($signed(a)) / longint'($signed(b));
            r = longint'($signed(a)) % longint'($signed(b));
            return {r[31:0], q[31:0]};
        end
        return {a % b, a / b};
    endfunction

    task automatic issue_op(input alu_op_t op, input word_t a, input word_t b, input shamt_t s);
        @(negedge clk);
        alu_op = op;
        src_a  = a;
        src_b  = b;
        sa     = s;
        issue  = 1'b1;
        #SETTLE;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        issue = 1'b0;
        flush = 1'b0;
        #SETTLE;
    endtask

    task automatic drive_stall_m(input logic v);
        @(negedge clk);
        stall_m = v;
        #SETTLE;
    endtask

    task automatic wait_stall_end();
        int guard;
        guard = 0;
        while (stall_e === 1'b1) begin
            next_cycle();
            guard++;
            if (guard > STALL_LIMIT) begin
                $display("timeout: the stall never ended within %0d cycles", STALL_LIMIT);
                abort_run();
            end
        end
    endtask

    task automatic run_mult(input logic signed_op);
        word_t a;
        word_t b;
        int    i;
        a = rand_operand();
        b = rand_operand();
        issue_op(signed_op ? `EXEC_OP_MULT : `EXEC_OP_MULTU, a, b, '0);
        for (i = 0; i < `EXEC_MULT_CYCLES; i++) begin
            check_bit("stall_e", stall_e, 1'b1);
            next_cycle();
        end
        check_bit("stall_e", stall_e, 1'b0);
        next_cycle();  // hi/lo written on this edge
        check_dword("hilo", hilo, model_mult(signed_op, a, b));
    endtask

    task automatic run_div(input logic signed_op, input word_t a, input word_t b);
        issue_op(signed_op ? `EXEC_OP_DIV : `EXEC_OP_DIVU, a, b, '0);
        check_bit("stall_e", stall_e, 1'b1);
        wait_stall_end();
        next_cycle();
        check_dword("hilo", hilo, model_div(signed_op, a, b));
    endtask

    initial begin
        int      i;
        alu_op_t op;
        word_t   a;
        word_t   b;
        shamt_t  s;
        dword_t  exp_hilo;

        seed    = 32'h8d7131d2;
        rst_n   = 1'b0;
        issue   = 1'b0;
        flush   = 1'b0;
        stall_m = 1'b0;
        alu_op  = '0;
        src_a   = '0;
        src_b   = '0;
        sa      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #SETTLE;
        check_bit("stall_e", stall_e, 1'b0);
        check_dword("hilo", hilo, '0);

        for (i = 0; i < N_SINGLE; i++) begin
            op = alu_op_t'(($random(seed) & 32'h7fff_ffff) % (`EXEC_OP_PASS + 1));
            a  = rand_operand();
            b  = rand_operand();
            s  = shamt_t'($random(seed));
            issue_op(op, a, b, s);
            check_word("result", result, model_alu(op, a, b, s));
            check_bit("overflow", overflow, model_ovf(op, a, b));
            check_bit("stall_e", stall_e, 1'b0);
            next_cycle();
        end

        for (i = 0; i < N_LONG; i++) begin
            run_mult(1'($random(seed)));
        end

        for (i = 0; i < N_LONG; i++) begin
            run_div(1'($random(seed)), rand_operand(), rand_operand());
        end
        run_div(1'b1, 32'h8000_0000, 32'hffff_ffff);
        run_div(1'b1, 32'hffff_fff9, '0);  // negative dividend over zero divisor
        run_div(1'b0, rand_operand(), '0);

        // mthi and mtlo each keep the other half
        exp_hilo = hilo;
        a = rand_operand();
        issue_op(`EXEC_OP_MTHI, a, '0, '0);
        next_cycle();
        exp_hilo[63:32] = a;
        check_dword("hilo", hilo, exp_hilo);
        b = rand_operand();
        issue_op(`EXEC_OP_MTLO, b, '0, '0);
        next_cycle();
        exp_hilo[31:0] = b;
        check_dword("hilo", hilo, exp_hilo);

        // completed multiply held back by stall_m
        a = rand_operand();
        b = rand_operand();
        drive_stall_m(1'b1);
        issue_op(`EXEC_OP_MULT, a, b, '0);
        wait_stall_end();
        for (i = 0; i < 4; i++) begin
            check_dword("hilo", hilo, exp_hilo);
            check_bit("stall_e", stall_e, 1'b0);
            next_cycle();
        end
        drive_stall_m(1'b0);
        next_cycle();
        check_dword("hilo", hilo, model_mult(1'b1, a, b));

        // flush in the middle of a divide
        exp_hilo = hilo;
        issue_op(`EXEC_OP_DIV, rand_operand(), rand_operand(), '0);
        for (i = 0; i < 5; i++) begin
            check_bit("stall_e", stall_e, 1'b1);
            next_cycle();
        end
        @(negedge clk);
        flush = 1'b1;
        #SETTLE;
        next_cycle();
        check_bit("stall_e", stall_e, 1'b0);
        for (i = 0; i < FLUSH_WATCH; i++) begin
            check_dword("hilo", hilo, exp_hilo);
            check_bit("stall_e", stall_e, 1'b0);
            next_cycle();
        end
        run_div(1'b1, rand_operand(), rand_operand());
        run_mult(1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule
